// ==== filelist.f ====
+incdir+hw
hw/texture_pkg.sv
hw/pixel_line_buffer.sv
hw/window_assembler.sv
hw/descriptor_compare.sv
hw/texture_pipeline.sv
tests/texture_pipeline_assert.sv
tests/texture_pipeline_tb.sv

// ==== tests/texture_pipeline_tb.sv ====
`timescale 1ns/1ps
`include "texture_macros.svh"

module texture_pipeline_tb;

  localparam int COLS = `TP_COLS;
  localparam int ROWS = `TP_ROWS;
  localparam int LINES = `TP_WIN - 1;
  localparam int WINDOWS = (ROWS - LINES) * (COLS - LINES);
  localparam int CLK_PERIOD = 40;
  localparam int NUM_FRAMES = 7;
  localparam int WATCHDOG_CYCLES = NUM_FRAMES * COLS * ROWS * 4 + 500;
  localparam int DIR_DX [8] = '{1, 1, 0, -1, -1, -1, 0, 1};
  localparam int DIR_DY [8] = '{0, 1, 1, 1, 0, -1, -1, -1};

  logic                     clk;
  logic                     rst_i;
  texture_pkg::pixel_t      pixel_i;
  logic                     pixel_valid_i;
  texture_pkg::descriptor_t desc_o;
  logic                     code_valid_o;

  texture_pkg::pixel_t      frame [ROWS][COLS];
  texture_pkg::descriptor_t exp_desc [$];
  int                       exp_cycle [$];
  logic [31:0]              lfsr_state;
  int                       cycle_cnt;
  int                       recv_count;
  int                       value_errs;
  int                       timing_errs;
  int                       stream_errs;
  logic                     use_fixed;
  texture_pkg::descriptor_t fixed_desc;

  texture_pipeline #(.COLS(COLS), .ROWS(ROWS)) DUT (
    .clk          (clk),
    .rst_i        (rst_i),
    .pixel_i      (pixel_i),
    .pixel_valid_i(pixel_valid_i),
    .desc_o       (desc_o),
    .code_valid_o (code_valid_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // taps 32, 22, 2, 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr_bit());
    end
    return v;
  endfunction

  // window by its bottom-right pixel with dy counting upward
  function automatic texture_pkg::descriptor_t model_desc(input int br, input int bc);
    texture_pkg::descriptor_t d;
    int cr;
    int cc;
    int sum;
    int inner;
    int outer;
    cr = br - 2;
    cc = bc - 2;
    sum = 0;
    for (int r = br - LINES; r <= br; r++) begin
      for (int c = bc - LINES; c <= bc; c++) begin
        sum += int'(frame[r][c]);
      end
    end
    for (int k = 0; k < 8; k++) begin
      inner = int'(frame[cr - DIR_DY[k]][cc + DIR_DX[k]]);
      outer = int'(frame[cr - 2 * DIR_DY[k]][cc + 2 * DIR_DX[k]]);
      d.rd[k] = (outer >= inner);
      d.ni[k] = (outer * `TP_WIN_AREA >= sum);
    end
    return d;
  endfunction

  task automatic check_code(input string label, input texture_pkg::code_t actual,
                            input texture_pkg::code_t expected);
    if (actual !== expected) begin
      value_errs++;
      $display("** Error at %0t: %s actual %h expected %h", $time, label, actual, expected);
    end
  endtask

  task automatic check_count(input string label, input int actual, input int expected);
    if (actual != expected) begin
      stream_errs++;
      $display("** Error at %0t: %s actual %0d expected %0d", $time, label, actual, expected);
    end
  endtask

  task automatic check_latency(input int actual, input int expected);
    if (actual != expected) begin
      timing_errs++;
      $display("** Error at %0t: code_valid_o cycle actual %0d expected %0d",
               $time, actual, expected);
    end
  endtask

  // codes are seen at the edge after code_valid_o rises
  always @(posedge clk) begin
    texture_pkg::descriptor_t exp;
    int due;
    cycle_cnt = cycle_cnt + 1;
    if (!rst_i && code_valid_o) begin
      recv_count++;
      if (exp_desc.size() == 0) begin
        stream_errs++;
        $display("%0t: code_valid_o pulsed with no window outstanding", $time);
      end else begin
        exp = exp_desc.pop_front();
        due = exp_cycle.pop_front();
        check_code("desc_o.rd", desc_o.rd, exp.rd);
        check_code("desc_o.ni", desc_o.ni, exp.ni);
        check_latency(cycle_cnt, due);
        if (use_fixed) begin
          check_code("desc_o.rd", desc_o.rd, fixed_desc.rd);
          check_code("desc_o.ni", desc_o.ni, fixed_desc.ni);
        end
      end
    end
  end

  task automatic do_reset();
    rst_i = 1'b1;
    pixel_valid_i = 1'b0;
    repeat (3) @(posedge clk);
    #2;
    rst_i = 1'b0;
    recv_count = 0;
  endtask

  // 0 flat, 1 ramp, 2 random
  task automatic fill_frame(input int kind);
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        case (kind)
          0:       frame[r][c] = 8'd100;
          1:       frame[r][c] = texture_pkg::pixel_t'(10 * c);
          default: frame[r][c] = texture_pkg::pixel_t'(rand_bits(8));
        endcase
      end
    end
  endtask

  // code is seen three edges after the accepting edge
  task automatic send_pixel(input int r, input int c, input int gap);
    pixel_i = frame[r][c];
    pixel_valid_i = 1'b1;
    if (r >= LINES && c >= LINES) begin
      exp_desc.push_back(model_desc(r, c));
      exp_cycle.push_back(cycle_cnt + 4);
    end
    @(posedge clk);
    #2;
    pixel_valid_i = 1'b0;
    repeat (gap) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic send_rows(input int rows, input int gap_bits);
    for (int r = 0; r < rows; r++) begin
      for (int c = 0; c < COLS; c++) begin
        send_pixel(r, c, (gap_bits > 0) ? rand_bits(gap_bits) : 0);
      end
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_desc.size() > 0 && n < 8) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (exp_desc.size() > 0) begin
      stream_errs++;
      $display("%0t: %0d expected code strobes never arrived", $time, exp_desc.size());
      exp_desc.delete();
      exp_cycle.delete();
    end
    // room for a stray strobe to show up
    repeat (4) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic test_reset();
    do_reset();
    fill_frame(2);
    send_rows(LINES, 0);
    wait_drain();
    check_count("windows in first rows", recv_count, 0);
  endtask

  task automatic test_fixed(input int kind, input texture_pkg::code_t code);
    do_reset();
    fill_frame(kind);
    use_fixed = 1'b1;
    fixed_desc.rd = code;
    fixed_desc.ni = code;
    send_rows(ROWS, 0);
    wait_drain();
    use_fixed = 1'b0;
    check_count("windows per frame", recv_count, WINDOWS);
  endtask

  task automatic test_random(input int gap_bits);
    do_reset();
    fill_frame(2);
    send_rows(ROWS, gap_bits);
    wait_drain();
    check_count("windows per frame", recv_count, WINDOWS);
  endtask

  task automatic test_back_to_back();
    do_reset();
    fill_frame(2);
    send_rows(ROWS, 0);
    fill_frame(2);
    send_rows(ROWS, 0);
    wait_drain();
    check_count("windows in two frames", recv_count, 2 * WINDOWS);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired before the tests completed");
    $display("Something failed");
    $finish;
  end

  initial begin
    clk = 1'b0;
    rst_i = 1'b1;
    pixel_i = '0;
    pixel_valid_i = 1'b0;
    lfsr_state = 32'h72bc_67f4;
    cycle_cnt = 0;
    recv_count = 0;
    value_errs = 0;
    timing_errs = 0;
    stream_errs = 0;
    use_fixed = 1'b0;
    fixed_desc = '0;
    test_reset();
    test_fixed(0, 8'hff);
    // only the west-side directions clear
    test_fixed(1, 8'hc7);
    test_random(0);
    test_random(2);
    test_back_to_back();
    $display("errors: value %0d, timing %0d, stream %0d", value_errs, timing_errs, stream_errs);
    if (value_errs + timing_errs + stream_errs == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== tests/texture_pipeline_assert.sv ====
`timescale 1ns/1ps

module texture_pipeline_assert (
  input logic clk,
  input logic rst_i,
  input logic pixel_valid_i,
  input logic col_valid_i,
  input logic win_valid_i,
  input logic code_valid_i
);

  // no code strobe straight out of reset
  a_reset_quiet: assert property (@(posedge clk) rst_i |=> !code_valid_i)
    else $error("code_valid_o high in the cycle after reset");

  // code strobe one cycle after its window and three after its pixel
  a_code_follows_win: assert property (@(posedge clk) disable iff (rst_i)
    code_valid_i |-> $past(win_valid_i) && $past(pixel_valid_i, 3))
    else $error("code_valid_o without win_valid one cycle or a pixel three cycles before");

  a_col_after_pixel: assert property (@(posedge clk) disable iff (rst_i)
    col_valid_i |-> $past(pixel_valid_i))
    else $error("col_valid without an accepted pixel");

endmodule

bind texture_pipeline texture_pipeline_assert u_assert (
  .clk          (clk),
  .rst_i        (rst_i),
  .pixel_valid_i(pixel_valid_i),
  .col_valid_i  (col_valid),
  .win_valid_i  (win_valid),
  .code_valid_i (code_valid_o)
);

// ==== hw/texture_pipeline.sv ====
`timescale 1ns/1ps
`include "texture_macros.svh"

module texture_pipeline #(
  parameter int COLS = `TP_COLS,
  parameter int ROWS = `TP_ROWS
) (
  input  logic                     clk,
  input  logic                     rst_i,
  input  texture_pkg::pixel_t      pixel_i,
  input  logic                     pixel_valid_i,
  output texture_pkg::descriptor_t desc_o,
  output logic                     code_valid_o
);

  texture_pkg::pixel_column_t col;
  logic                       col_shift;
  logic                       col_valid;
  texture_pkg::ring_t         ring;
  logic                       win_valid;

  // stage 1, frame position and line memories
  pixel_line_buffer #(
    .COLS(COLS),
    .ROWS(ROWS)
  ) u_line_buffer (
    .clk          (clk),
    .rst_i        (rst_i),
    .pixel_i      (pixel_i),
    .pixel_valid_i(pixel_valid_i),
    .col_o        (col),
    .col_shift_o  (col_shift),
    .col_valid_o  (col_valid)
  );

  // stage 2, 5x5 window and ring samples
  window_assembler u_window (
    .clk        (clk),
    .rst_i      (rst_i),
    .col_i      (col),
    .col_shift_i(col_shift),
    .col_valid_i(col_valid),
    .ring_o     (ring),
    .win_valid_o(win_valid)
  );

  // stage 3, rd and ni codes
  descriptor_compare u_compare (
    .clk         (clk),
    .rst_i       (rst_i),
    .ring_i      (ring),
    .win_valid_i (win_valid),
    .desc_o      (desc_o),
    .code_valid_o(code_valid_o)
  );

endmodule

// ==== hw/descriptor_compare.sv ====
`timescale 1ns/1ps
`include "texture_macros.svh"

module descriptor_compare (
  input  logic                     clk,
  input  logic                     rst_i,
  input  texture_pkg::ring_t       ring_i,
  input  logic                     win_valid_i,
  output texture_pkg::descriptor_t desc_o,
  output logic                     code_valid_o
);

  localparam int DIRS = $bits(texture_pkg::code_t);

  texture_pkg::code_t      rd_next;
  texture_pkg::code_t      ni_next;
  texture_pkg::patch_sum_t scaled [DIRS];

  always_comb begin
    for (int k = 0; k < DIRS; k++) begin
      // outer sample against the patch mean, scaled up by the area
      scaled[k] = texture_pkg::patch_sum_t'(ring_i.outer[k]) *
                  texture_pkg::patch_sum_t'(`TP_WIN_AREA);
      rd_next[k] = (ring_i.outer[k] >= ring_i.inner[k]);
      ni_next[k] = (scaled[k] >= ring_i.sum);
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      code_valid_o <= 1'b0;
    end else begin
      code_valid_o <= win_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (win_valid_i) begin
      desc_o.rd <= rd_next;
      desc_o.ni <= ni_next;
    end
  end

endmodule

// ==== hw/window_assembler.sv ====
`timescale 1ns/1ps
`include "texture_macros.svh"

module window_assembler (
  input  logic                       clk,
  input  logic                       rst_i,
  input  texture_pkg::pixel_column_t col_i,
  input  logic                       col_shift_i,
  input  logic                       col_valid_i,
  output texture_pkg::ring_t         ring_o,
  output logic                       win_valid_o
);

  // inner offsets per direction, dy counts upward
  localparam int DX [8] = '{1, 1, 0, -1, -1, -1, 0, 1};
  localparam int DY [8] = '{0, 1, 1, 1, 0, -1, -1, -1};
  localparam int MID = `TP_WIN / 2;

  texture_pkg::pixel_column_t win      [`TP_WIN];
  texture_pkg::pixel_column_t win_next [`TP_WIN];
  texture_pkg::patch_sum_t    col_sum  [`TP_WIN];
  texture_pkg::patch_sum_t    patch_sum;
  texture_pkg::patch_sum_t    new_sum;
  texture_pkg::patch_sum_t    sum_next;
  texture_pkg::ring_t         ring_next;

  function automatic texture_pkg::pixel_t col_px(input texture_pkg::pixel_column_t c,
                                                 input int r);
    case (r)
      0:       return c.row0;
      1:       return c.row1;
      2:       return c.row2;
      3:       return c.row3;
      default: return c.row4;
    endcase
  endfunction

  function automatic texture_pkg::patch_sum_t col_total(input texture_pkg::pixel_column_t c);
    texture_pkg::patch_sum_t acc;
    acc = '0;
    for (int r = 0; r < `TP_WIN; r++) begin
      acc = acc + texture_pkg::patch_sum_t'(col_px(c, r));
    end
    return acc;
  endfunction

  // window after the pending shift, column 4 is east
  always_comb begin
    for (int c = 0; c < `TP_WIN - 1; c++) begin
      win_next[c] = win[c+1];
    end
    win_next[`TP_WIN-1] = col_i;
    new_sum  = col_total(col_i);
    sum_next = patch_sum + new_sum - col_sum[0];
    ring_next.centre = col_px(win_next[MID], MID);
    for (int k = 0; k < 8; k++) begin
      ring_next.inner[k] = col_px(win_next[MID + DX[k]], MID - DY[k]);
      ring_next.outer[k] = col_px(win_next[MID + 2 * DX[k]], MID - 2 * DY[k]);
    end
    ring_next.sum = sum_next;
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int c = 0; c < `TP_WIN; c++) begin
        col_sum[c] <= '0;
      end
      patch_sum   <= '0;
      win_valid_o <= 1'b0;
    end else begin
      win_valid_o <= col_valid_i;
      if (col_shift_i) begin
        for (int c = 0; c < `TP_WIN - 1; c++) begin
          col_sum[c] <= col_sum[c+1];
        end
        col_sum[`TP_WIN-1] <= new_sum;
        patch_sum <= sum_next;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (col_shift_i) begin
      for (int c = 0; c < `TP_WIN; c++) begin
        win[c] <= win_next[c];
      end
    end
    if (col_valid_i) begin
      ring_o <= ring_next;
    end
  end

endmodule

// ==== hw/pixel_line_buffer.sv ====
`timescale 1ns/1ps
`include "texture_macros.svh"

module pixel_line_buffer #(
  parameter int COLS = `TP_COLS,
  parameter int ROWS = `TP_ROWS
) (
  input  logic                       clk,
  input  logic                       rst_i,
  input  texture_pkg::pixel_t        pixel_i,
  input  logic                       pixel_valid_i,
  output texture_pkg::pixel_column_t col_o,
  output logic                       col_shift_o,
  output logic                       col_valid_o
);

  localparam int LINES = `TP_WIN - 1;
  localparam int COL_W = (COLS > 1) ? $clog2(COLS) : 1;
  localparam int ROW_W = (ROWS > 1) ? $clog2(ROWS) : 1;

  logic [COL_W-1:0] col_cnt;
  logic [ROW_W-1:0] row_cnt;
  logic             last_col;
  logic             last_row;
  logic             interior;

  // line k holds the row k+1 above the incoming one
  texture_pkg::pixel_t line_mem [LINES][COLS];
  texture_pkg::pixel_t tap [LINES];

  assign last_col = (col_cnt == COL_W'(COLS - 1));
  assign last_row = (row_cnt == ROW_W'(ROWS - 1));

  // bottom-right corner of a full 5x5 window
  assign interior = (row_cnt >= ROW_W'(LINES)) && (col_cnt >= COL_W'(LINES));

  always_comb begin
    for (int k = 0; k < LINES; k++) begin
      // rows above the frame top read as zero
      tap[k] = (row_cnt > ROW_W'(k)) ? line_mem[k][col_cnt] : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      col_cnt     <= '0;
      row_cnt     <= '0;
      col_shift_o <= 1'b0;
      col_valid_o <= 1'b0;
    end else begin
      col_shift_o <= pixel_valid_i;
      col_valid_o <= pixel_valid_i && interior;
      if (pixel_valid_i) begin
        if (last_col) begin
          col_cnt <= '0;
          row_cnt <= last_row ? '0 : row_cnt + 1'b1;
        end else begin
          col_cnt <= col_cnt + 1'b1;
        end
      end
    end
  end

  // column out and line shift on the same address
  always_ff @(posedge clk) begin
    if (pixel_valid_i) begin
      col_o.row0 <= tap[3];
      col_o.row1 <= tap[2];
      col_o.row2 <= tap[1];
      col_o.row3 <= tap[0];
      col_o.row4 <= pixel_i;
      line_mem[0][col_cnt] <= pixel_i;
      for (int k = 1; k < LINES; k++) begin
        line_mem[k][col_cnt] <= line_mem[k-1][col_cnt];
      end
    end
  end

endmodule

// ==== hw/texture_pkg.sv ====
`include "texture_macros.svh"

package texture_pkg;

  typedef logic [`TP_PIXEL_W-1:0] pixel_t;

  // sum of the 5x5 patch, or 25 times one pixel
  typedef logic [`TP_SUM_W-1:0] patch_sum_t;

  // bit k is direction k*45 deg counter-clockwise from east
  typedef logic [7:0] code_t;

  // one window column, top row first
  typedef struct packed {
    pixel_t row0;
    pixel_t row1;
    pixel_t row2;
    pixel_t row3;
    pixel_t row4;
  } pixel_column_t;

  // samples for one window position
  typedef struct packed {
    pixel_t       centre;
    pixel_t [7:0] inner;
    pixel_t [7:0] outer;
    patch_sum_t   sum;
  } ring_t;

  typedef struct packed {
    code_t rd;
    code_t ni;
  } descriptor_t;

endpackage

// ==== hw/texture_macros.svh ====
`ifndef TEXTURE_MACROS_SVH
`define TEXTURE_MACROS_SVH

// grayscale sample width
`define TP_PIXEL_W 8

// default frame size
`define TP_COLS 16
`define TP_ROWS 12

// window side and area
`define TP_WIN 5
`define TP_WIN_AREA 25

// holds 25 x 255
`define TP_SUM_W 13

`endif
